//--- Makefile
VERILATOR ?= verilator
TOP ?= sm83CoreTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/sm83Pkg.sv
package sm83Pkg;

	typedef logic [7:0] byteT;	// Data, register and opcode byte.
	typedef logic [15:0] addrT;	// Memory address.
	typedef logic [3:0] flagsT;	// Flag nibble in Z N H C order.

	// Bit positions inside flagsT.
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	// Jump condition codes from the decoder.
	localparam logic [1:0] JCOND_NONE = 2'd0;
	localparam logic [1:0] JCOND_Z = 2'd1;
	localparam logic [1:0] JCOND_C = 2'd2;

	typedef enum logic [2:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR
	} aluOpT;

	typedef enum logic [2:0] {
		SEQ_FETCH, SEQ_DECODE, SEQ_READ_LO, SEQ_READ_HI,
		SEQ_EXECUTE, SEQ_WRITE, SEQ_HALTED
	} seqStateT;

	// Opcode bytes of the supported subset.
	localparam byteT OP_NOP = 8'h00;
	localparam byteT OP_LD_A_N = 8'h3E;
	localparam byteT OP_LD_B_N = 8'h06;
	localparam byteT OP_ADD_B = 8'h80;	// ADD A,B.
	localparam byteT OP_SUB_B = 8'h90;
	localparam byteT OP_AND_B = 8'hA0;
	localparam byteT OP_XOR_B = 8'hA8;
	localparam byteT OP_OR_B = 8'hB0;
	localparam byteT OP_LD_NN_A = 8'hEA;	// LD (a16),A.
	localparam byteT OP_JP = 8'hC3;
	localparam byteT OP_JP_Z = 8'hCA;
	localparam byteT OP_JP_C = 8'hDA;
	localparam byteT OP_HALT = 8'h76;

	localparam addrT RESET_PC = 16'h0000;	// First opcode fetch address.

endpackage

//--- design/core/busInterface.sv
`timescale 1ns/1ps

module busInterface #(
	parameter int BUS_TIMEOUT = 64
) (
	input  logic CLK,
	input  logic reset,
	input  logic busStart,
	input  logic busWrite,
	input  sm83Pkg::addrT busAddr,
	input  sm83Pkg::byteT busWdata,
	output logic busDone,
	output sm83Pkg::byteT readData,
	output logic busError,
	output logic memReq,
	output logic memWe,
	output sm83Pkg::addrT memAddr,
	output sm83Pkg::byteT memWdata,
	input  sm83Pkg::byteT memRdata,
	input  logic memAck
);

	localparam int CNT_W = $clog2(BUS_TIMEOUT + 1);

	typedef enum logic [1:0] {BUS_IDLE, BUS_WAIT_HIGH, BUS_WAIT_LOW} busStateT;

	busStateT busState;
	logic [CNT_W-1:0] waitCount;	// Cycles spent on the current edge.
	logic timedOut;

	assign timedOut = (waitCount == CNT_W'(BUS_TIMEOUT));
	assign busDone = (busState == BUS_WAIT_LOW) && !memAck;	// Ack seen low.

	always_ff @(posedge CLK) begin
		if (reset) begin
			busState <= BUS_IDLE;
			memReq <= 1'b0;
			memWe <= 1'b0;
			busError <= 1'b0;
			waitCount <= '0;
		end else begin
			case (busState)
				BUS_IDLE: begin
					waitCount <= '0;
					if (busStart && !busError) begin
						memAddr <= busAddr;	// Held until the next start.
						memWdata <= busWdata;
						memWe <= busWrite;
						memReq <= 1'b1;
						busState <= BUS_WAIT_HIGH;
					end
				end
				BUS_WAIT_HIGH: begin
					if (memAck) begin
						if (!memWe)
							readData <= memRdata;	// Valid while ack is high.
						memReq <= 1'b0;
						waitCount <= '0;
						busState <= BUS_WAIT_LOW;
					end else if (timedOut) begin
						memReq <= 1'b0;
						busError <= 1'b1;	// Sticky until reset.
						busState <= BUS_IDLE;
					end else
						waitCount <= waitCount + 1'b1;
				end
				BUS_WAIT_LOW: begin
					if (!memAck)
						busState <= BUS_IDLE;
					else if (timedOut) begin
						busError <= 1'b1;
						busState <= BUS_IDLE;
					end else
						waitCount <= waitCount + 1'b1;
				end
				default: busState <= BUS_IDLE;
			endcase
		end
	end

endmodule

//--- design/core/dataPath.sv
`timescale 1ns/1ps

module dataPath (
	input  logic CLK,
	input  logic reset,
	input  sm83Pkg::aluOpT aluOp,
	input  logic loadA,
	input  logic loadB,
	input  sm83Pkg::byteT operand,
	input  logic execStrobe,
	output sm83Pkg::byteT regA,
	output sm83Pkg::flagsT flags
);

	sm83Pkg::byteT regB;
	sm83Pkg::byteT aluResult;
	sm83Pkg::flagsT aluFlags;
	logic isAluOp;
	logic [8:0] wideSum;	// Bit 8 is the carry out.
	logic [8:0] wideDiff;	// Bit 8 is the borrow.
	logic [4:0] halfSum;
	logic [4:0] halfDiff;

	assign wideSum = {1'b0, regA} + {1'b0, regB};
	assign wideDiff = {1'b0, regA} - {1'b0, regB};
	assign halfSum = {1'b0, regA[3:0]} + {1'b0, regB[3:0]};	// Carry from bit 3.
	assign halfDiff = {1'b0, regA[3:0]} - {1'b0, regB[3:0]};	// Borrow from bit 4.
	assign isAluOp = (aluOp != sm83Pkg::ALU_PASS);

	always_comb begin
		aluResult = regA;
		aluFlags = flags;
		case (aluOp)
			sm83Pkg::ALU_ADD: begin
				aluResult = wideSum[7:0];
				aluFlags[sm83Pkg::FLAG_N] = 1'b0;
				aluFlags[sm83Pkg::FLAG_H] = halfSum[4];
				aluFlags[sm83Pkg::FLAG_C] = wideSum[8];
			end
			sm83Pkg::ALU_SUB: begin
				aluResult = wideDiff[7:0];
				aluFlags[sm83Pkg::FLAG_N] = 1'b1;
				aluFlags[sm83Pkg::FLAG_H] = halfDiff[4];
				aluFlags[sm83Pkg::FLAG_C] = wideDiff[8];
			end
			sm83Pkg::ALU_AND: begin
				aluResult = regA & regB;
				aluFlags[sm83Pkg::FLAG_N] = 1'b0;
				aluFlags[sm83Pkg::FLAG_H] = 1'b1;	// SM83 sets H on AND.
				aluFlags[sm83Pkg::FLAG_C] = 1'b0;
			end
			sm83Pkg::ALU_XOR, sm83Pkg::ALU_OR: begin
				aluResult = (aluOp == sm83Pkg::ALU_XOR) ? (regA ^ regB) : (regA | regB);
				aluFlags[sm83Pkg::FLAG_N] = 1'b0;
				aluFlags[sm83Pkg::FLAG_H] = 1'b0;
				aluFlags[sm83Pkg::FLAG_C] = 1'b0;
			end
			default: ;	// Pass keeps A and F.
		endcase
		if (isAluOp)
			aluFlags[sm83Pkg::FLAG_Z] = (aluResult == 8'h00);
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			regA <= '0;
			regB <= '0;
			flags <= '0;
		end else if (execStrobe) begin
			if (loadA)
				regA <= operand;
			else if (isAluOp)
				regA <= aluResult;	// Result always lands in A.
			if (loadB)
				regB <= operand;
			if (isAluOp)
				flags <= aluFlags;	// Loads leave F alone.
		end
	end

endmodule

//--- design/core/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  sm83Pkg::byteT ir,
	output logic [1:0] operandBytes,
	output sm83Pkg::aluOpT aluOp,
	output logic loadA,
	output logic loadB,
	output logic storeA,
	output logic isJump,
	output logic [1:0] jumpCond,
	output logic isHalt
);

	always_comb begin
		// NOP fields unless the opcode says otherwise.
		operandBytes = 2'd0;
		aluOp = sm83Pkg::ALU_PASS;
		loadA = 1'b0;
		loadB = 1'b0;
		storeA = 1'b0;
		isJump = 1'b0;
		jumpCond = sm83Pkg::JCOND_NONE;
		isHalt = 1'b0;
		case (ir)
			sm83Pkg::OP_LD_A_N: begin
				operandBytes = 2'd1;
				loadA = 1'b1;
			end
			sm83Pkg::OP_LD_B_N: begin
				operandBytes = 2'd1;
				loadB = 1'b1;
			end
			sm83Pkg::OP_ADD_B: aluOp = sm83Pkg::ALU_ADD;
			sm83Pkg::OP_SUB_B: aluOp = sm83Pkg::ALU_SUB;
			sm83Pkg::OP_AND_B: aluOp = sm83Pkg::ALU_AND;
			sm83Pkg::OP_XOR_B: aluOp = sm83Pkg::ALU_XOR;
			sm83Pkg::OP_OR_B: aluOp = sm83Pkg::ALU_OR;
			sm83Pkg::OP_LD_NN_A: begin
				operandBytes = 2'd2;	// Little endian a16.
				storeA = 1'b1;
			end
			sm83Pkg::OP_JP: begin
				operandBytes = 2'd2;
				isJump = 1'b1;
			end
			sm83Pkg::OP_JP_Z: begin
				operandBytes = 2'd2;
				isJump = 1'b1;
				jumpCond = sm83Pkg::JCOND_Z;
			end
			sm83Pkg::OP_JP_C: begin
				operandBytes = 2'd2;
				isJump = 1'b1;
				jumpCond = sm83Pkg::JCOND_C;
			end
			sm83Pkg::OP_HALT: isHalt = 1'b1;
			default: ;	// NOP and any unknown opcode.
		endcase
	end

endmodule

//--- design/core/sequencer.sv
`timescale 1ns/1ps

module sequencer (
	input  logic CLK,
	input  logic reset,
	output sm83Pkg::byteT irOut,
	input  logic [1:0] operandBytes,
	input  logic isJump,
	input  logic [1:0] jumpCond,
	input  logic isHalt,
	input  logic storeA,
	input  sm83Pkg::flagsT flags,
	input  sm83Pkg::byteT regA,
	input  sm83Pkg::byteT readData,
	input  logic busDone,
	input  logic busError,
	output logic busStart,
	output logic busWrite,
	output sm83Pkg::addrT busAddr,
	output sm83Pkg::byteT busWdata,
	output sm83Pkg::byteT operand,
	output logic execStrobe,
	output logic loadIr,
	output logic halted
);

	sm83Pkg::seqStateT state;
	sm83Pkg::addrT pc;
	sm83Pkg::byteT ir;
	sm83Pkg::addrT operandLatch;	// Immediate byte or a16 operand.
	logic busBusy;	// An access is in flight.
	logic needBus;
	logic jumpTaken;

	assign needBus = (state == sm83Pkg::SEQ_FETCH) || (state == sm83Pkg::SEQ_READ_LO) ||
		(state == sm83Pkg::SEQ_READ_HI) || (state == sm83Pkg::SEQ_WRITE);

	// Condition check for JP, JP Z and JP C.
	always_comb begin
		case (jumpCond)
			sm83Pkg::JCOND_Z: jumpTaken = isJump && flags[sm83Pkg::FLAG_Z];
			sm83Pkg::JCOND_C: jumpTaken = isJump && flags[sm83Pkg::FLAG_C];
			default: jumpTaken = isJump;
		endcase
	end

	assign irOut = ir;
	assign operand = operandLatch[7:0];	// Low byte feeds the LD loads.
	assign busWrite = (state == sm83Pkg::SEQ_WRITE);
	assign busAddr = busWrite ? operandLatch : pc;	// Store target or code stream.
	assign busWdata = regA;
	assign execStrobe = (state == sm83Pkg::SEQ_EXECUTE);	// Exactly one cycle.
	assign halted = (state == sm83Pkg::SEQ_HALTED);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= sm83Pkg::SEQ_FETCH;
			pc <= sm83Pkg::RESET_PC;
			busBusy <= 1'b0;
			busStart <= 1'b0;
			loadIr <= 1'b0;
		end else begin
			busStart <= 1'b0;	// Pulse by default.
			loadIr <= 1'b0;
			if (needBus && !busBusy && !busError) begin
				busStart <= 1'b1;	// Request one access.
				busBusy <= 1'b1;
			end
			if (busDone)
				busBusy <= 1'b0;
			case (state)
				sm83Pkg::SEQ_FETCH: begin
					if (busDone) begin
						ir <= readData;	// New opcode.
						pc <= pc + 16'd1;
						loadIr <= 1'b1;
						state <= sm83Pkg::SEQ_DECODE;
					end
				end
				sm83Pkg::SEQ_DECODE: begin
					if (isHalt)
						state <= sm83Pkg::SEQ_HALTED;
					else if (operandBytes == 2'd0)
						state <= sm83Pkg::SEQ_EXECUTE;	// ALU ops and NOP.
					else
						state <= sm83Pkg::SEQ_READ_LO;
				end
				sm83Pkg::SEQ_READ_LO: begin
					if (busDone) begin
						operandLatch[7:0] <= readData;
						pc <= pc + 16'd1;
						state <= (operandBytes == 2'd2) ? sm83Pkg::SEQ_READ_HI :
							sm83Pkg::SEQ_EXECUTE;
					end
				end
				sm83Pkg::SEQ_READ_HI: begin
					if (busDone) begin
						operandLatch[15:8] <= readData;
						pc <= pc + 16'd1;
						state <= storeA ? sm83Pkg::SEQ_WRITE : sm83Pkg::SEQ_EXECUTE;
					end
				end
				sm83Pkg::SEQ_EXECUTE: begin
					if (jumpTaken)
						pc <= operandLatch;	// Otherwise fall through.
					state <= sm83Pkg::SEQ_FETCH;
				end
				sm83Pkg::SEQ_WRITE: begin
					if (busDone)
						state <= sm83Pkg::SEQ_FETCH;
				end
				default: state <= sm83Pkg::SEQ_HALTED;	// Stays here until reset.
			endcase
		end
	end

endmodule

//--- design/core/sm83Core.sv
`timescale 1ns/1ps

module sm83Core #(
	parameter int BUS_TIMEOUT = 64	// Cycles allowed for each memAck edge.
) (
	input  logic CLK,
	input  logic reset,
	input  sm83Pkg::byteT memRdata,
	input  logic memAck,
	output logic memReq,
	output logic memWe,
	output sm83Pkg::addrT memAddr,
	output sm83Pkg::byteT memWdata,
	output logic loadIr,	// Like SYNC of old processors.
	output logic halted,
	output logic busError
);

	// Decoder fields.
	sm83Pkg::byteT irOut;
	logic [1:0] operandBytes;
	sm83Pkg::aluOpT aluOp;
	logic loadA;
	logic loadB;
	logic storeA;
	logic isJump;
	logic [1:0] jumpCond;
	logic isHalt;

	// Data path links.
	sm83Pkg::byteT operand;
	logic execStrobe;
	sm83Pkg::byteT regA;
	sm83Pkg::flagsT flags;

	// Bus unit links.
	logic busStart;
	logic busWrite;
	sm83Pkg::addrT busAddr;
	sm83Pkg::byteT busWdata;
	logic busDone;
	sm83Pkg::byteT readData;

	sequencer seq_i (
		.CLK(CLK), .reset(reset), .irOut(irOut), .operandBytes(operandBytes),
		.isJump(isJump), .jumpCond(jumpCond), .isHalt(isHalt), .storeA(storeA),
		.flags(flags), .regA(regA), .readData(readData), .busDone(busDone),
		.busError(busError), .busStart(busStart), .busWrite(busWrite),
		.busAddr(busAddr), .busWdata(busWdata), .operand(operand),
		.execStrobe(execStrobe), .loadIr(loadIr), .halted(halted));

	decoder dec_i (
		.ir(irOut), .operandBytes(operandBytes), .aluOp(aluOp), .loadA(loadA),
		.loadB(loadB), .storeA(storeA), .isJump(isJump), .jumpCond(jumpCond),
		.isHalt(isHalt));

	dataPath dp_i (
		.CLK(CLK), .reset(reset), .aluOp(aluOp), .loadA(loadA), .loadB(loadB),
		.operand(operand), .execStrobe(execStrobe), .regA(regA), .flags(flags));

	busInterface #(.BUS_TIMEOUT(BUS_TIMEOUT)) biu_i (
		.CLK(CLK), .reset(reset), .busStart(busStart), .busWrite(busWrite),
		.busAddr(busAddr), .busWdata(busWdata), .busDone(busDone),
		.readData(readData), .busError(busError), .memReq(memReq), .memWe(memWe),
		.memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata), .memAck(memAck));

endmodule

//--- filelist.f
common/sm83Pkg.sv
design/core/decoder.sv
design/core/dataPath.sv
design/core/busInterface.sv
design/core/sequencer.sv
design/core/sm83Core.sv
verif/clockGen.sv
verif/sm83Core_asserts.sv
verif/sm83CoreTb.sv

//--- verif/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD = 20,	// Clock period in ns.
	parameter int RESET_CYCLES = 5
) (
	output logic CLK,
	output logic reset
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		reset = 1'b1;	// Power-on reset.
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 reset = 1'b0;
	end

endmodule

//--- verif/sm83CoreTb.sv
`timescale 1ns/1ps

module sm83CoreTb;

	localparam int HALT_LIMIT = 300000;	// Cycles allowed per program.

	logic CLK, porReset, pulseReset, coreReset;
	logic memReq, memWe, memAck, loadIr, halted, busError;
	sm83Pkg::addrT memAddr;
	sm83Pkg::byteT memWdata, memRdata;
	sm83Pkg::byteT mem [0:65535];
	sm83Pkg::byteT prog[$];	// Program image from address 0.
	sm83Pkg::addrT expAddr[$], logAddr[$];
	sm83Pkg::byteT expData[$], logData[$];
	sm83Pkg::byteT pairA [4], pairB [4], aluOpcode [5];
	logic [15:0] lfsr;
	logic randomDelay;	// Back-pressure mode.
	int testErrors, testsRun, testsFailed;
	int expLoads;	// Expected loadIr pulses for the executed opcodes.

	clockGen clk_i (.CLK(CLK), .reset(porReset));
	assign coreReset = porReset | pulseReset;

	sm83Core #(.BUS_TIMEOUT(64)) dut_i (
		.CLK(CLK), .reset(coreReset), .memRdata(memRdata), .memAck(memAck),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.loadIr(loadIr), .halted(halted), .busError(busError));

	// Galois LFSR stepped once per bit taken.
	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Memory side of the four-phase handshake.
	always begin
		int cnt;
		@(posedge CLK);
		#1;
		if (memReq && !memAck && !coreReset) begin
			repeat (randomDelay ? randBits(3) : 0) begin
				@(posedge CLK);
				#1;
			end
			if (memWe) begin
				mem[memAddr] = memWdata;
				logAddr.push_back(memAddr);
				logData.push_back(memWdata);
			end else
				memRdata = mem[memAddr];
			memAck = 1'b1;
			cnt = 0;
			do begin
				@(posedge CLK);
				#1;
				cnt++;
			end while (memReq && cnt < 100);
			repeat (randomDelay ? randBits(3) : 0) begin
				@(posedge CLK);
				#1;
			end
			memAck = 1'b0;
		end
	end

	task automatic emit(input sm83Pkg::byteT b);
		prog.push_back(b);
	endtask

	task automatic emit3(input sm83Pkg::byteT op, input sm83Pkg::addrT a);
		emit(op);
		emit(a[7:0]);	// Little endian.
		emit(a[15:8]);
	endtask

	task automatic expectWrite(input sm83Pkg::addrT a, input sm83Pkg::byteT d);
		expAddr.push_back(a);
		expData.push_back(d);
	endtask

	// Reference ALU returning {Z, C, result}.
	function automatic logic [9:0] refAlu(input sm83Pkg::byteT a, input sm83Pkg::byteT b,
			input int op);
		int r;
		logic c;
		c = 1'b0;
		case (op)
			0: begin
				r = int'(a) + int'(b);
				c = (r > 255);
			end
			1: begin
				r = int'(a) - int'(b);
				c = (r < 0);
			end
			2: r = int'(a & b);
			3: r = int'(a ^ b);
			default: r = int'(a | b);
		endcase
		return {(r[7:0] == 8'h00), c, r[7:0]};
	endfunction

	task automatic startTest();
		prog.delete();
		expAddr.delete();
		expData.delete();
		expLoads = 0;
		testErrors = 0;
	endtask

	// Loads the program, restarts the core and checks the write log.
	task automatic runProgram(input string name);
		int cnt;
		int loads;
		for (int i = 0; i < 65536; i++)
			mem[i] = sm83Pkg::byteT'(i[7:0] ^ i[15:8] ^ 8'h5C);
		foreach (prog[i])
			mem[i] = prog[i];
		logAddr.delete();
		logData.delete();
		@(posedge CLK);
		#1 pulseReset = 1'b1;
		repeat (5) @(posedge CLK);
		#1 pulseReset = 1'b0;
		cnt = 0;
		loads = 0;
		while (!halted && cnt < HALT_LIMIT) begin
			@(posedge CLK);
			#1;
			cnt++;
			if (loadIr)
				loads++;	// One pulse per fetched opcode.
		end
		if (!halted) begin
			$display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
			testErrors++;
		end
		if (busError) begin
			$display("%s: busError was raised", name);
			testErrors++;
		end
		if (loads != expLoads) begin
			$display("[ERROR] %s: loadIr pulses expected %0d actual %0d", name,
				expLoads, loads);
			testErrors++;
		end
		if (logAddr.size() != expAddr.size()) begin
			$display("[ERROR] %s: write count expected %0d actual %0d", name,
				expAddr.size(), logAddr.size());
			testErrors++;
		end else
			foreach (expAddr[i])
				if (logAddr[i] !== expAddr[i] || logData[i] !== expData[i]) begin
					$display("[ERROR] %s: write %0d expected %h=%h actual %h=%h", name, i,
						expAddr[i], expData[i], logAddr[i], logData[i]);
					testErrors++;
				end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		$display("%s %s", (testErrors == 0) ? "[PASS]" : "[FAIL]", name);
	endtask

	task automatic testLoadStore(input string sfx);
		startTest();
		emit(sm83Pkg::OP_LD_A_N);
		emit(8'h5A);
		emit3(sm83Pkg::OP_LD_NN_A, 16'h8000);
		emit(sm83Pkg::OP_HALT);
		expectWrite(16'h8000, 8'h5A);
		expLoads = 3;
		runProgram({"loadStore", sfx});
		finishTest({"loadStore", sfx});
	endtask

	// ALU results or flag markers through JP Z and JP C.
	task automatic testAlu(input string sfx, input bit branch);
		logic [9:0] r;
		int t;
		startTest();
		for (int p = 0; p < 4; p++)
			for (int op = 0; op < 5; op++) begin
				r = refAlu(pairA[p], pairB[p], op);
				for (int c = 0; c < (branch ? 2 : 1); c++) begin
					emit(sm83Pkg::OP_LD_A_N);
					emit(pairA[p]);
					emit(sm83Pkg::OP_LD_B_N);
					emit(pairB[p]);
					emit(aluOpcode[op]);
					if (branch) begin
						t = prog.size() + 8;	// Taken path label.
						emit3((c == 0) ? sm83Pkg::OP_JP_Z : sm83Pkg::OP_JP_C, 16'(t));
						emit(sm83Pkg::OP_LD_A_N);
						emit(8'h01);
						emit3(sm83Pkg::OP_JP, 16'(t + 2));
						emit(sm83Pkg::OP_LD_A_N);
						emit(8'h02);
						emit3(sm83Pkg::OP_LD_NN_A, 16'(16'h9000 + p * 10 + op * 2 + c));
						expectWrite(16'(16'h9000 + p * 10 + op * 2 + c),
							r[9 - c] ? 8'h02 : 8'h01);
						expLoads += r[9 - c] ? 6 : 7;	// Taken path skips LD A,01 and JP.
					end else begin
						emit3(sm83Pkg::OP_LD_NN_A, 16'(16'h8000 + p * 5 + op));
						expectWrite(16'(16'h8000 + p * 5 + op), r[7:0]);
						expLoads += 4;
					end
				end
			end
		emit(sm83Pkg::OP_HALT);
		expLoads += 1;
		runProgram({branch ? "flagJumps" : "aluOps", sfx});
		finishTest({branch ? "flagJumps" : "aluOps", sfx});
	endtask

	task automatic testJumpNop(input string sfx);
		startTest();
		emit(sm83Pkg::OP_LD_A_N);
		emit(8'h33);
		emit3(sm83Pkg::OP_JP, 16'h0008);
		emit3(sm83Pkg::OP_LD_NN_A, 16'h8100);	// Skipped store.
		emit(8'hD3);	// Unknown opcode at 0x0008.
		emit(sm83Pkg::OP_NOP);
		emit3(sm83Pkg::OP_LD_NN_A, 16'h8101);
		emit(sm83Pkg::OP_HALT);
		expectWrite(16'h8101, 8'h33);
		expLoads = 6;
		runProgram({"jumpNop", sfx});
		finishTest({"jumpNop", sfx});
	endtask

	task automatic testHalt();
		int rises;
		logic lastReq;
		startTest();
		emit(sm83Pkg::OP_LD_A_N);
		emit(8'h01);
		emit(sm83Pkg::OP_HALT);
		emit3(sm83Pkg::OP_LD_NN_A, 16'h8200);	// Must never run.
		expLoads = 2;
		runProgram("halt");
		rises = 0;
		lastReq = memReq;
		repeat (50) begin
			@(posedge CLK);
			#1;
			if (memReq && !lastReq)
				rises++;
			lastReq = memReq;
		end
		if (rises != 0 || !halted) begin
			$display("[ERROR] halt: memReq rises expected 0 actual %0d, halted %b", rises, halted);
			testErrors++;
		end
		finishTest("halt");
	endtask

	initial begin
		int cnt;
		pulseReset = 1'b0;
		memAck = 1'b0;
		memRdata = 8'h00;
		randomDelay = 1'b0;
		lfsr = 16'(36016);
		testsRun = 0;
		testsFailed = 0;
		expLoads = 0;
		pairA = '{8'h01, 8'h3C, 8'hF0, 8'h80};
		pairB = '{8'h0F, 8'h3C, 8'h21, 8'h80};
		aluOpcode = '{sm83Pkg::OP_ADD_B, sm83Pkg::OP_SUB_B, sm83Pkg::OP_AND_B,
			sm83Pkg::OP_XOR_B, sm83Pkg::OP_OR_B};
		cnt = 0;
		while (porReset && cnt < 100) begin
			@(posedge CLK);
			cnt++;
		end
		testLoadStore("");
		testAlu("", 1'b0);
		testAlu("", 1'b1);
		testJumpNop("");
		testHalt();
		randomDelay = 1'b1;	// Rerun with random ack delays.
		testLoadStore("BackPressure");
		testAlu("BackPressure", 1'b0);
		testAlu("BackPressure", 1'b1);
		testJumpNop("BackPressure");
		$display("Tests run %0d, failed %0d", testsRun, testsFailed);
		if (testsFailed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verif/sm83Core_asserts.sv
`timescale 1ns/1ps

module sm83Core_asserts (
	input logic CLK,
	input logic reset,
	input logic memReq,
	input logic memWe,
	input logic memAck,
	input sm83Pkg::addrT memAddr,
	input sm83Pkg::byteT memWdata
);

	// Request fields hold while the request is up.
	reqStable: assert property (@(posedge CLK) disable iff (reset)
		(memReq && $past(memReq)) |-> ($stable(memAddr) && $stable(memWe) && $stable(memWdata)))
		else $error("memAddr, memWe or memWdata changed while memReq was high");

	// A new request waits for ack low.
	noRiseOnAck: assert property (@(posedge CLK) disable iff (reset)
		$rose(memReq) |-> !$past(memAck))
		else $error("memReq rose while memAck was high");

	resetIdle: assert property (@(posedge CLK) $past(reset) |-> (!memReq && !memWe))
		else $error("memReq or memWe high after reset");

endmodule

bind sm83Core sm83Core_asserts asserts_i (
	.CLK(CLK), .reset(reset), .memReq(memReq), .memWe(memWe), .memAck(memAck),
	.memAddr(memAddr), .memWdata(memWdata));
